// File: rtl/stall_defines.svh
`ifndef STALL_DEFINES_SVH
`define STALL_DEFINES_SVH

// ------------------------------
// Widths
// ------------------------------

// Message payload width in bits
`define STALL_MSG_W 16

// Max delay and countdown width, so delays up to 255 cycles
`define STALL_DELAY_W 8

// ------------------------------
// LFSR seeds
// ------------------------------

// Nonzero, and distinct so the two stages draw different sequences
`define STALL_SEED_IN  16'hACE1
`define STALL_SEED_OUT 16'h5EED

`endif

// File: rtl/stall_pkg.sv
`include "stall_defines.svh"

package stall_pkg;

  // ------------------------------
  // Shared types
  // ------------------------------

  // Message carried on every valid/ready link
  typedef logic [`STALL_MSG_W-1:0] stall_msg_t;

  // Max delay inputs and delay countdowns
  typedef logic [`STALL_DELAY_W-1:0] stall_delay_t;

  // Delay stage FSM
  typedef enum logic {
    STALL_IDLE = 1'b0,
    STALL_WAIT = 1'b1
  } stall_state_t;

endpackage

// File: rtl/stall_rand_delay.sv
`timescale 1ns/1ns

module stall_rand_delay #(
  // LFSR start value, must be nonzero
  parameter logic [15:0] SEED = 16'h0001
) (
  input  logic                 clk,
  input  logic                 reset,

  // Run-time max delay, zero means pass-through
  input  stall_pkg::stall_delay_t max_delay,

  // Upstream side
  input  logic                 in_val,
  output logic                 in_rdy,
  input  stall_pkg::stall_msg_t   in_msg,

  // Downstream side
  output logic                 out_val,
  input  logic                 out_rdy,
  output stall_pkg::stall_msg_t   out_msg
);

  import stall_pkg::*;

  // ------------------------------
  // LFSR
  // ------------------------------

  // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  localparam int LFSR_W = 16;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

  logic [LFSR_W-1:0] lfsr;
  logic [LFSR_W-1:0] lfsr_next;

  // Shift right, fold taps back in when the bit shifted out is set
  assign lfsr_next = {1'b0, lfsr[LFSR_W-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);

  // ------------------------------
  // Delay draw
  // ------------------------------

  // Zero max turns the whole stage into wires
  logic pass_thru;
  assign pass_thru = (max_delay == '0);

  // Draw = LFSR value modulo the max
  // Guarded so a zero max never divides by zero
  logic [LFSR_W-1:0] lfsr_mod;
  stall_delay_t      draw;

  assign lfsr_mod = pass_thru ? '0 : (lfsr % LFSR_W'(max_delay));

  // Result is below max_delay so it fits the delay width
  assign draw = stall_delay_t'(lfsr_mod);

  // ------------------------------
  // State and countdown
  // ------------------------------

  stall_state_t state;
  stall_state_t state_next;
  stall_delay_t count;
  stall_delay_t count_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STALL_IDLE;
      count <= '0;
      lfsr  <= SEED;
    end else begin
      state <= state_next;
      count <= count_next;
      // Steps every cycle regardless of traffic
      lfsr  <= lfsr_next;
    end
  end

  // ------------------------------
  // Next state and outputs
  // ------------------------------

  always_comb begin
    // Hold by default
    state_next = state;
    count_next = count;
    out_val    = 1'b0;

    if (pass_thru) begin
      // Combinational pass-through, nothing to count
      out_val    = in_val;
      state_next = STALL_IDLE;
      count_next = '0;
    end else begin
      case (state)
        STALL_IDLE: begin
          // Zero draw forwards in the same cycle
          out_val = in_val && (draw == '0);

          // Message seen but not taken this cycle
          if (in_val && !(out_val && out_rdy)) begin
            state_next = STALL_WAIT;
            // Idle cycle already counts as the first cycle of the wait
            // zero draw with back-pressure parks at count zero
            count_next = (draw == '0) ? '0 : draw - 1'b1;
          end
        end

        STALL_WAIT: begin
          // Offer the message once the countdown has run out
          out_val = in_val && (count == '0);

          if (count != '0) begin
            count_next = count - 1'b1;
          end else if (in_val && out_rdy) begin
            // Transfer done, back to idle for the next message
            state_next = STALL_IDLE;
          end
        end

        default: begin
          state_next = STALL_IDLE;
          count_next = '0;
        end
      endcase
    end
  end

  // Upstream sees ready only on the cycle the message leaves
  // In pass-through mode ready just follows downstream
  assign in_rdy = pass_thru ? out_rdy : (out_val && out_rdy);

  // Data is never stored here, only delayed by holding valid low
  assign out_msg = in_msg;

endmodule

// File: rtl/stall_skid_buffer.sv
`timescale 1ns/1ns

module stall_skid_buffer (
  input  logic                 clk,
  input  logic                 reset,

  // Upstream side
  input  logic                 in_val,
  output logic                 in_rdy,
  input  stall_pkg::stall_msg_t   in_msg,

  // Downstream side
  output logic                 out_val,
  input  logic                 out_rdy,
  output stall_pkg::stall_msg_t   out_msg
);

  import stall_pkg::*;

  // ------------------------------
  // Storage and pointers
  // ------------------------------

  // Two message slots used as a tiny ring
  stall_msg_t mem [2];

  // Slot holding the oldest message
  logic       head;

  // Number of held messages, 0 to 2
  logic [1:0] count;

  logic push;
  logic pop;
  logic wr_ptr;

  // Both handshakes come from registered state on this side
  assign in_rdy  = (count != 2'd2);
  assign out_val = (count != 2'd0);
  assign out_msg = mem[head];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // First free slot after the head
  assign wr_ptr = head ^ count[0];

  // ------------------------------
  // Control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= 1'b0;
      count <= 2'd0;
    end else begin
      // Push only, pop only, or both with count unchanged
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end

      if (pop) begin
        head <= ~head;
      end
    end
  end

  // ------------------------------
  // Data
  // ------------------------------

  // Slot write, a full buffer never pushes so no overwrite
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_msg;
    end
  end

endmodule

// File: rtl/stall_shaper_top.sv
`timescale 1ns/1ns

`include "stall_defines.svh"

module stall_shaper_top (
  input  logic                 clk,
  input  logic                 reset,

  // Run-time maxima, one per delay stage
  input  stall_pkg::stall_delay_t max_delay_in,
  input  stall_pkg::stall_delay_t max_delay_out,

  // Upstream side
  input  logic                 in_val,
  output logic                 in_rdy,
  input  stall_pkg::stall_msg_t   in_msg,

  // Downstream side
  output logic                 out_val,
  input  logic                 out_rdy,
  output stall_pkg::stall_msg_t   out_msg
);

  import stall_pkg::*;

  // Input delay stage to skid buffer
  logic       mid_val;
  logic       mid_rdy;
  stall_msg_t mid_msg;

  // Skid buffer to output delay stage
  logic       skid_val;
  logic       skid_rdy;
  stall_msg_t skid_msg;

  // ------------------------------
  // Input delay
  // ------------------------------

  stall_rand_delay #(
    .SEED (`STALL_SEED_IN)
  ) u_delay_in (
    .clk       (clk),
    .reset     (reset),
    .max_delay (max_delay_in),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .in_msg    (in_msg),
    .out_val   (mid_val),
    .out_rdy   (mid_rdy),
    .out_msg   (mid_msg)
  );

  // ------------------------------
  // Skid buffer
  // ------------------------------

  // Registered handshakes here break the ready path between the stages
  stall_skid_buffer u_skid (
    .clk     (clk),
    .reset   (reset),
    .in_val  (mid_val),
    .in_rdy  (mid_rdy),
    .in_msg  (mid_msg),
    .out_val (skid_val),
    .out_rdy (skid_rdy),
    .out_msg (skid_msg)
  );

  // ------------------------------
  // Output delay
  // ------------------------------

  stall_rand_delay #(
    .SEED (`STALL_SEED_OUT)
  ) u_delay_out (
    .clk       (clk),
    .reset     (reset),
    .max_delay (max_delay_out),
    .in_val    (skid_val),
    .in_rdy    (skid_rdy),
    .in_msg    (skid_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_msg   (out_msg)
  );

endmodule

// File: sim/stall_props.sv
`timescale 1ns/1ns

module stall_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  in_rdy,
  input logic                  out_val,
  input logic                  out_rdy,
  input stall_pkg::stall_msg_t out_msg
);

  // ------------------------------
  // Output handshake
  // ------------------------------

  // An offer that is not taken stays up with the same message
  property p_out_hold;
    @(posedge clk) disable iff (reset)
      (out_val && !out_rdy) |=> (out_val && $stable(out_msg));
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("out_val dropped or out_msg changed while out_rdy was low");

  // ------------------------------
  // Reset behavior
  // ------------------------------

  // Handshake outputs are always driven once out of reset
  property p_known;
    @(posedge clk) disable iff (reset)
      !$isunknown({in_rdy, out_val});
  endproperty

  a_known: assert property (p_known)
    else $error("in_rdy or out_val is unknown after reset");

  // Buffer is empty right after reset, nothing offered downstream
  property p_reset_empty;
    @(posedge clk) reset |=> !out_val;
  endproperty

  a_reset_empty: assert property (p_reset_empty)
    else $error("out_val high in the cycle after reset");

endmodule

// Attach to every instance of the top level
bind stall_shaper_top stall_props u_props (
  .clk     (clk),
  .reset   (reset),
  .in_rdy  (in_rdy),
  .out_val (out_val),
  .out_rdy (out_rdy),
  .out_msg (out_msg)
);

// File: sim/stall_tb.sv
`timescale 1ns/1ns

module stall_tb;

  import stall_pkg::*;

  // 16 + 32 + 16 + 16 messages over all tests
  localparam int TOTAL_MSGS = 80;

  // Worst isolated message is 15 + 1 + 15 cycles, random ready about halves throughput
  // 80 x 31 x 2 stays far below this
  localparam int TIMEOUT_CYCLES = 20000;

  logic         clk;
  logic         reset;
  logic         in_val;
  logic         in_rdy;
  stall_msg_t   in_msg;
  logic         out_val;
  logic         out_rdy;
  stall_msg_t   out_msg;
  stall_delay_t max_delay_in;
  stall_delay_t max_delay_out;

  // ------------------------------
  // Scoreboard state
  // ------------------------------

  // Accepted messages and the cycle of their input transfer
  stall_msg_t exp_msg_q[$];
  int         exp_cyc_q[$];

  int cycle = 0;
  int n_in = 0;
  int n_out = 0;

  // Exact one-cycle latency expected
  bit check_exact = 1'b0;
  // Largest allowed gap, 0 means unchecked
  int max_gap = 0;

  // Stimulus LFSR
  logic [15:0] rand_state = 16'h0003;

  stall_shaper_top UUT (
    .clk           (clk),
    .reset         (reset),
    .max_delay_in  (max_delay_in),
    .max_delay_out (max_delay_out),
    .in_val        (in_val),
    .in_rdy        (in_rdy),
    .in_msg        (in_msg),
    .out_val       (out_val),
    .out_rdy       (out_rdy),
    .out_msg       (out_msg)
  );

  always #5 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  // Galois step, x^16 + x^15 + x^13 + x^4 + 1, returns the bit shifted out
  function automatic logic next_rand_bit();
    logic b;
    b = rand_state[0];
    rand_state = {1'b0, rand_state[15:1]} ^ (b ? 16'hD008 : 16'h0000);
    return b;
  endfunction

  // One LFSR step per message bit
  function automatic stall_msg_t rand_msg();
    stall_msg_t m;
    m = '0;
    for (int i = 0; i < $bits(stall_msg_t); i++) begin
      m = (m << 1) | stall_msg_t'(next_rand_bit());
    end
    return m;
  endfunction

  // Output side compare, latency and gap checks
  task automatic check_output();
    stall_msg_t exp;
    int         t_in;
    assert (exp_msg_q.size() > 0) else begin
      $display("Output transfer with no message outstanding, out_msg %h", out_msg);
      stop_on_error();
    end
    exp  = exp_msg_q.pop_front();
    t_in = exp_cyc_q.pop_front();
    assert (out_msg === exp) else begin
      $display("ERR out_msg expected %h got %h", exp, out_msg);
      stop_on_error();
    end
    if (check_exact) begin
      assert (cycle - t_in == 1) else begin
        $display("Message %h left %0d cycles after its input, expected 1",
                 exp, cycle - t_in);
        stop_on_error();
      end
    end
    if (max_gap > 0) begin
      // Gap from the input transfer to this output transfer
      assert (cycle - t_in <= max_gap) else begin
        $display("Message %h waited %0d cycles, limit is %0d",
                 exp, cycle - t_in, max_gap);
        stop_on_error();
      end
    end
    n_out++;
  endtask

  // Handshakes sampled mid-cycle, inputs settled and equal to their value at the next edge
  always @(negedge clk) begin
    if (!reset) begin
      if (in_val && in_rdy) begin
        exp_msg_q.push_back(in_msg);
        exp_cyc_q.push_back(cycle);
        n_in++;
      end
      if (out_val && out_rdy) begin
        check_output();
      end
    end
  end

  // Entered and left 1 ns after a rising edge
  task automatic send_msg(input stall_msg_t msg, output int waits);
    logic taken;
    in_val = 1'b1;
    in_msg = msg;
    taken  = 1'b0;
    waits  = 0;
    while (!taken) begin
      @(negedge clk);
      taken = in_rdy;
      waits++;
      @(posedge clk);
    end
    #1;
    in_val = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_msg_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic check_reset_state();
    repeat (10) begin
      @(negedge clk);
      assert (out_val === 1'b0) else begin
        $display("ERR out_val expected %h got %h", 1'b0, out_val);
        stop_on_error();
      end
      @(posedge clk);
    end
    #1;
  endtask

  task automatic zero_delay_stream();
    int waits;
    max_delay_in  = 8'd0;
    max_delay_out = 8'd0;
    out_rdy       = 1'b1;
    check_exact   = 1'b1;
    for (int i = 0; i < 16; i++) begin
      send_msg(rand_msg(), waits);
      // Back to back means accepted at the first edge
      assert (waits == 1) else begin
        $display("Input stalled %0d cycles in the zero-delay stream", waits - 1);
        stop_on_error();
      end
    end
    wait_drain();
    check_exact = 1'b0;
  endtask

  task automatic random_delay_order();
    int waits;
    max_delay_in  = 8'd7;
    max_delay_out = 8'd7;
    out_rdy       = 1'b1;
    max_gap       = 7 + 1 + 7;
    for (int i = 0; i < 32; i++) begin
      send_msg(rand_msg(), waits);
    end
    wait_drain();
    max_gap = 0;
  endtask

  task automatic back_pressure_burst();
    stall_msg_t msgs[$];
    logic       fired;
    max_delay_in  = 8'd3;
    max_delay_out = 8'd3;
    // Messages drawn first so ready bits come after them in the LFSR sequence
    for (int i = 0; i < 16; i++) begin
      msgs.push_back(rand_msg());
    end
    while (msgs.size() != 0 || exp_msg_q.size() != 0) begin
      in_val = (msgs.size() != 0);
      if (msgs.size() != 0) begin
        in_msg = msgs[0];
      end
      out_rdy = next_rand_bit();
      @(negedge clk);
      fired = in_val && in_rdy;
      @(posedge clk);
      #1;
      if (fired) begin
        void'(msgs.pop_front());
      end
    end
    in_val  = 1'b0;
    out_rdy = 1'b1;
  endtask

  task automatic max_delay_switch();
    int waits;
    max_delay_in  = 8'd15;
    max_delay_out = 8'd15;
    out_rdy       = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_msg(rand_msg(), waits);
    end
    wait_drain();
    // No reset here, stages must fall back to pass-through
    max_delay_in  = 8'd0;
    max_delay_out = 8'd0;
    check_exact   = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_msg(rand_msg(), waits);
      assert (waits == 1) else begin
        $display("Input stalled %0d cycles after the switch to zero delay", waits - 1);
        stop_on_error();
      end
    end
    wait_drain();
    check_exact = 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    in_val        = 1'b0;
    in_msg        = '0;
    out_rdy       = 1'b1;
    max_delay_in  = 8'd0;
    max_delay_out = 8'd0;

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    check_reset_state();
    zero_delay_stream();
    random_delay_order();
    back_pressure_burst();
    max_delay_switch();

    // Quiet tail, a duplicate would show up as an unexpected output
    idle_cycles(40);

    if (n_in == TOTAL_MSGS && n_out == TOTAL_MSGS && exp_msg_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Message count wrong at end: %0d in, %0d out, %0d outstanding",
               n_in, n_out, exp_msg_q.size());
      $display("sim failed");
      $fatal(1, "message count");
    end
  end

endmodule

// File: project.f
+incdir+rtl
rtl/stall_pkg.sv
rtl/stall_rand_delay.sv
rtl/stall_skid_buffer.sv
rtl/stall_shaper_top.sv
sim/stall_props.sv
sim/stall_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stall shaper testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module stall_tb -f project.f -o stall_sim

./obj_dir/stall_sim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
